/* hdl/serpentAlgPkg.sv */
package serpentAlgPkg;

	localparam int BLOCK_WIDTH = 128;
	localparam int WORD_WIDTH = 32;
	localparam int KEY_WIDTH = 256;
	localparam int ROUNDS = 32;

	localparam logic [WORD_WIDTH-1:0] PHI = 32'h9e3779b9; // Fractional part of the golden ratio

	// Row n is S-box Sn, indexed by the 4-bit column value
	localparam logic [3:0] SBOX [8][16] = '{
		'{4'h3, 4'h8, 4'hf, 4'h1, 4'ha, 4'h6, 4'h5, 4'hb,
		  4'he, 4'hd, 4'h4, 4'h2, 4'h7, 4'h0, 4'h9, 4'hc},
		'{4'hf, 4'hc, 4'h2, 4'h7, 4'h9, 4'h0, 4'h5, 4'ha,
		  4'h1, 4'hb, 4'he, 4'h8, 4'h6, 4'hd, 4'h3, 4'h4},
		'{4'h8, 4'h6, 4'h7, 4'h9, 4'h3, 4'hc, 4'ha, 4'hf,
		  4'hd, 4'h1, 4'he, 4'h4, 4'h0, 4'hb, 4'h5, 4'h2},
		'{4'h0, 4'hf, 4'hb, 4'h8, 4'hc, 4'h9, 4'h6, 4'h3,
		  4'hd, 4'h1, 4'h2, 4'h4, 4'ha, 4'h7, 4'h5, 4'he},
		'{4'h1, 4'hf, 4'h8, 4'h3, 4'hc, 4'h0, 4'hb, 4'h6,
		  4'h2, 4'h5, 4'h4, 4'ha, 4'h9, 4'he, 4'h7, 4'hd},
		'{4'hf, 4'h5, 4'h2, 4'hb, 4'h4, 4'ha, 4'h9, 4'hc,
		  4'h0, 4'h3, 4'he, 4'h8, 4'hd, 4'h6, 4'h7, 4'h1},
		'{4'h7, 4'h2, 4'hc, 4'h5, 4'h8, 4'h4, 4'h6, 4'hb,
		  4'he, 4'h9, 4'h1, 4'hf, 4'hd, 4'h3, 4'ha, 4'h0},
		'{4'h1, 4'hd, 4'hf, 4'h0, 4'he, 4'h8, 4'h2, 4'hb,
		  4'h7, 4'h4, 4'hc, 4'ha, 4'h9, 4'h3, 4'h5, 4'h6}
	};

	// Left rotation of one bitslice word, amount between 1 and 31
	function automatic logic [WORD_WIDTH-1:0] rotl
	(
		input logic [WORD_WIDTH-1:0] value,
		input int unsigned amount
	);
		return (value << amount) | (value >> (WORD_WIDTH - amount));
	endfunction

endpackage

/* hdl/serpentCtrlPkg.sv */
package serpentCtrlPkg;

	localparam int ROUND_WIDTH = 6; // Holds 0 to 32, the last value selects K32

	// The controller spends one cycle per round and one more for the last key
	typedef enum logic [1:0]
	{
		IDLE,
		ROUND,
		FINAL
	} CtrlState;

endpackage

/* hdl/serpentSboxLayer.sv */
`timescale 1ns/1ps

module serpentSboxLayer
(
	input logic [serpentAlgPkg::BLOCK_WIDTH-1:0] dataIn,
	input logic [2:0] sBoxSelect,
	output logic [serpentAlgPkg::BLOCK_WIDTH-1:0] dataOut
);

	import serpentAlgPkg::*;

	genvar j;

	// Bit j of every word forms one column, word 0 as the low bit
	for (j = 0; j < WORD_WIDTH; j++)
	begin : gColumn
		logic [3:0] column;
		logic [3:0] mapped;

		assign column =
		{
			dataIn[3 * WORD_WIDTH + j],
			dataIn[2 * WORD_WIDTH + j],
			dataIn[WORD_WIDTH + j],
			dataIn[j]
		};

		assign mapped = SBOX[sBoxSelect][column];

		assign dataOut[j] = mapped[0];
		assign dataOut[WORD_WIDTH + j] = mapped[1];
		assign dataOut[2 * WORD_WIDTH + j] = mapped[2];
		assign dataOut[3 * WORD_WIDTH + j] = mapped[3];
	end

endmodule

/* hdl/serpentControl.sv */
`timescale 1ns/1ps

module serpentControl
(
	input logic clk,
	input logic rst,
	input logic go,
	output logic load,
	output logic step,
	output logic finalAdd,
	output logic [2:0] sBoxSelect,
	output logic [serpentCtrlPkg::ROUND_WIDTH-1:0] round,
	output logic busy,
	output logic done
);

	import serpentAlgPkg::*;
	import serpentCtrlPkg::*;

	CtrlState state;
	CtrlState nextState;

	assign load = (state == IDLE) && go; // A go outside IDLE is dropped
	assign step = (state == ROUND);
	assign finalAdd = (state == FINAL);
	assign busy = (state != IDLE);

	always_comb
	begin
		nextState = state;
		case (state)
		IDLE:
		begin
			if (go)
			begin
				nextState = ROUND;
			end
		end
		ROUND:
		begin
			if (round == ROUND_WIDTH'(ROUNDS - 1))
			begin
				nextState = FINAL;
			end
		end
		FINAL:
		begin
			nextState = IDLE;
		end
		default:
		begin
			nextState = IDLE;
		end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			round <= '0;
			sBoxSelect <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			done <= finalAdd; // One cycle after the last key addition
			if (load)
			begin
				round <= '0;
				sBoxSelect <= '0;
			end
			else if (step)
			begin
				round <= round + 1'b1; // Reaches 32 for the FINAL cycle
				sBoxSelect <= sBoxSelect + 1'b1;
			end
		end
	end

endmodule

/* hdl/serpentKeySchedule.sv */
`timescale 1ns/1ps

module serpentKeySchedule
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic step,
	input logic finalAdd,
	input logic [serpentCtrlPkg::ROUND_WIDTH-1:0] round,
	input logic [serpentAlgPkg::KEY_WIDTH-1:0] key,
	output logic [serpentAlgPkg::BLOCK_WIDTH-1:0] subKey
);

	import serpentAlgPkg::*;
	import serpentCtrlPkg::*;

	logic [WORD_WIDTH-1:0] window [8]; // Entry 0 is the oldest prekey
	logic [WORD_WIDTH-1:0] prekey [12];
	logic [BLOCK_WIDTH-1:0] newWords;
	logic [2:0] keyBoxSelect;

	// Entries 8 to 11 are the prekeys 4i to 4i+3 for round index i
	always_comb
	begin
		for (int k = 0; k < 8; k++)
		begin
			prekey[k] = window[k];
		end
		for (int k = 0; k < 4; k++)
		begin
			prekey[k + 8] = rotl(prekey[k] ^ prekey[k + 3] ^ prekey[k + 5] ^ prekey[k + 7]
				^ PHI ^ WORD_WIDTH'({round, 2'(k)}), 11);
		end
	end

	assign newWords = {prekey[11], prekey[10], prekey[9], prekey[8]};
	assign keyBoxSelect = 3'd3 - round[2:0]; // Counts down from S3 as the rounds advance

	serpentSboxLayer i_keySbox
	(
		.dataIn(newWords),
		.sBoxSelect(keyBoxSelect),
		.dataOut(subKey)
	);

	always_ff @(posedge clk)
	begin
		if (rst || finalAdd)
		begin
			for (int k = 0; k < 8; k++)
			begin
				window[k] <= '0; // Key material is wiped once K32 is consumed
			end
		end
		else if (load)
		begin
			for (int k = 0; k < 8; k++)
			begin
				window[k] <= key[k * WORD_WIDTH +: WORD_WIDTH];
			end
		end
		else if (step)
		begin
			for (int k = 0; k < 8; k++)
			begin
				window[k] <= prekey[k + 4];
			end
		end
	end

endmodule

/* hdl/serpentRoundData.sv */
`timescale 1ns/1ps

module serpentRoundData
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic step,
	input logic finalAdd,
	input logic [2:0] sBoxSelect,
	input logic [serpentAlgPkg::BLOCK_WIDTH-1:0] plainText,
	input logic [serpentAlgPkg::BLOCK_WIDTH-1:0] subKey,
	output logic [serpentAlgPkg::BLOCK_WIDTH-1:0] cipherText
);

	import serpentAlgPkg::*;

	logic [BLOCK_WIDTH-1:0] blockState;
	logic [BLOCK_WIDTH-1:0] mixed;
	logic [BLOCK_WIDTH-1:0] substituted;
	logic [BLOCK_WIDTH-1:0] transformed;
	logic [WORD_WIDTH-1:0] x0;
	logic [WORD_WIDTH-1:0] x1;
	logic [WORD_WIDTH-1:0] x2;
	logic [WORD_WIDTH-1:0] x3;
	logic [1:0] octetCount;
	logic lastOctet;
	logic lastRound;

	assign mixed = blockState ^ subKey;

	serpentSboxLayer i_dataSbox
	(
		.dataIn(mixed),
		.sBoxSelect(sBoxSelect),
		.dataOut(substituted)
	);

	always_comb
	begin
		x0 = rotl(substituted[0 +: WORD_WIDTH], 13);
		x2 = rotl(substituted[2 * WORD_WIDTH +: WORD_WIDTH], 3);
		x1 = substituted[WORD_WIDTH +: WORD_WIDTH] ^ x0 ^ x2;
		x3 = substituted[3 * WORD_WIDTH +: WORD_WIDTH] ^ x2 ^ (x0 << 3);
		x1 = rotl(x1, 1);
		x3 = rotl(x3, 7);
		x0 = x0 ^ x1 ^ x3;
		x2 = x2 ^ x3 ^ (x1 << 7);
		x0 = rotl(x0, 5);
		x2 = rotl(x2, 22);
		transformed = {x3, x2, x1, x0};
	end

	// Round 31 is the fourth round that uses S7
	assign lastRound = lastOctet && (sBoxSelect == 3'd7);

	always_ff @(posedge clk)
	begin
		if (rst || load)
		begin
			octetCount <= '0;
			lastOctet <= 1'b0;
		end
		else if (step && (sBoxSelect == 3'd7))
		begin
			octetCount <= octetCount + 1'b1;
			if (octetCount == 2'd2)
			begin
				lastOctet <= 1'b1; // Set after round 23
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			blockState <= plainText;
		end
		else if (step)
		begin
			blockState <= lastRound ? substituted : transformed;
		end
		else if (finalAdd)
		begin
			blockState <= blockState ^ subKey; // Whitening with K32
		end
	end

	assign cipherText = blockState;

endmodule

/* hdl/serpentTop.sv */
`timescale 1ns/1ps

module serpentTop
(
	input logic clk,
	input logic rst,
	input logic go,
	input logic [serpentAlgPkg::BLOCK_WIDTH-1:0] plainText,
	input logic [serpentAlgPkg::KEY_WIDTH-1:0] key,
	output logic [serpentAlgPkg::BLOCK_WIDTH-1:0] cipherText,
	output logic busy,
	output logic done
);

	import serpentAlgPkg::*;
	import serpentCtrlPkg::*;

	logic load;
	logic step;
	logic finalAdd;
	logic [2:0] sBoxSelect;
	logic [ROUND_WIDTH-1:0] round;
	logic [BLOCK_WIDTH-1:0] subKey;

	serpentControl i_control
	(
		.clk(clk),
		.rst(rst),
		.go(go),
		.load(load),
		.step(step),
		.finalAdd(finalAdd),
		.sBoxSelect(sBoxSelect),
		.round(round),
		.busy(busy),
		.done(done)
	);

	serpentKeySchedule i_keySchedule
	(
		.clk(clk),
		.rst(rst),
		.load(load),
		.step(step),
		.finalAdd(finalAdd),
		.round(round),
		.key(key),
		.subKey(subKey)
	);

	serpentRoundData i_roundData
	(
		.clk(clk),
		.rst(rst),
		.load(load),
		.step(step),
		.finalAdd(finalAdd),
		.sBoxSelect(sBoxSelect),
		.plainText(plainText),
		.subKey(subKey),
		.cipherText(cipherText)
	);

endmodule

/* verification/serpentTop_properties.sv */
`timescale 1ns/1ps

module serpentTopProperties
(
	input logic clk,
	input logic rst,
	input logic go,
	input logic busy,
	input logic done
);

	doneSingleCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else $error("done stayed high for more than one cycle");

	// Done rises at the 33rd edge after go is taken, so its first high sample comes one edge later
	doneLatency: assert property (@(posedge clk) disable iff (rst) (go && !busy) |-> ##34 done)
	else $error("done did not follow an accepted go after 33 cycles");

	idleAtDone: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
	else $error("busy was high while done was high");

	quietAfterReset: assert property (@(posedge clk) rst |=> (!busy && !done))
	else $error("busy or done was high in the cycle after reset");

endmodule

bind serpentTop serpentTopProperties i_properties
(
	.clk(clk),
	.rst(rst),
	.go(go),
	.busy(busy),
	.done(done)
);

/* verification/serpentTb.sv */
`timescale 1ns/1ps

module serpentTb;

	import serpentAlgPkg::*;

	logic clk;
	logic rst;
	logic go;
	logic [BLOCK_WIDTH-1:0] plainText;
	logic [KEY_WIDTH-1:0] key;
	logic [BLOCK_WIDTH-1:0] cipherText;
	logic busy;
	logic done;

	logic [31:0] lcgState;
	logic [BLOCK_WIDTH-1:0] expectedCipher; // Updated at the edge where go is taken
	string testName;
	int doneCount;
	int checkErrors;
	int assertErrors;
	int timeoutErrors;

	serpentTop i_dut
	(
		.clk(clk),
		.rst(rst),
		.go(go),
		.plainText(plainText),
		.key(key),
		.cipherText(cipherText),
		.busy(busy),
		.done(done)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [BLOCK_WIDTH-1:0] randomBlock();
		logic [BLOCK_WIDTH-1:0] value;
		for (int k = 0; k < 4; k++)
		begin
			value[32 * k +: 32] = lcgNext();
		end
		return value;
	endfunction

	function automatic logic [KEY_WIDTH-1:0] randomKey();
		logic [KEY_WIDTH-1:0] value;
		for (int k = 0; k < 8; k++)
		begin
			value[32 * k +: 32] = lcgNext();
		end
		return value;
	endfunction

	function automatic logic [31:0] rotateWord(input logic [31:0] value, input int amount);
		logic [63:0] doubled;
		doubled = {value, value} >> (32 - amount);
		return doubled[31:0];
	endfunction

	function automatic logic [BLOCK_WIDTH-1:0] sboxColumns
	(
		input logic [BLOCK_WIDTH-1:0] value,
		input logic [2:0] box
	);
		logic [BLOCK_WIDTH-1:0] result;
		logic [3:0] nibble;
		logic [3:0] entry;
		result = '0;
		for (int col = 0; col < 32; col++)
		begin
			for (int b = 0; b < 4; b++)
			begin
				nibble[b] = value[32 * b + col]; // Word b gives bit b of the column
			end
			entry = SBOX[box][nibble];
			for (int b = 0; b < 4; b++)
			begin
				result[32 * b + col] = entry[b];
			end
		end
		return result;
	endfunction

	function automatic logic [BLOCK_WIDTH-1:0] linearTransform
	(
		input logic [BLOCK_WIDTH-1:0] value
	);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		a = rotateWord(value[31:0], 13);
		c = rotateWord(value[95:64], 3);
		b = value[63:32] ^ a ^ c;
		d = value[127:96] ^ c ^ (a << 3);
		b = rotateWord(b, 1);
		d = rotateWord(d, 7);
		a = a ^ b ^ d;
		c = c ^ d ^ (b << 7);
		a = rotateWord(a, 5);
		c = rotateWord(c, 22);
		return {d, c, b, a};
	endfunction

	function automatic logic [BLOCK_WIDTH-1:0] serpentModel
	(
		input logic [BLOCK_WIDTH-1:0] plain,
		input logic [KEY_WIDTH-1:0] userKey
	);
		logic [31:0] w [140]; // Entry j holds prekey j - 8
		logic [BLOCK_WIDTH-1:0] roundKey [33];
		logic [BLOCK_WIDTH-1:0] state;
		for (int j = 0; j < 8; j++)
		begin
			w[j] = userKey[32 * j +: 32];
		end
		for (int j = 8; j < 140; j++)
		begin
			w[j] = rotateWord(w[j - 8] ^ w[j - 5] ^ w[j - 3] ^ w[j - 1] ^ PHI ^ 32'(j - 8), 11);
		end
		for (int i = 0; i < 33; i++)
		begin
			roundKey[i] = sboxColumns({w[4 * i + 11], w[4 * i + 10], w[4 * i + 9], w[4 * i + 8]},
				3'(3 - i));
		end
		state = plain;
		for (int i = 0; i < ROUNDS; i++)
		begin
			state = sboxColumns(state ^ roundKey[i], 3'(i));
			if (i != ROUNDS - 1)
			begin
				state = linearTransform(state);
			end
		end
		return state ^ roundKey[32];
	endfunction

	task automatic driveGoPulse
	(
		input logic [BLOCK_WIDTH-1:0] plain,
		input logic [KEY_WIDTH-1:0] userKey
	);
		@(posedge clk);
		go <= 1'b1;
		plainText <= plain;
		key <= userKey;
		@(posedge clk);
		go <= 1'b0;
	endtask

	task automatic startOperation
	(
		input logic [BLOCK_WIDTH-1:0] plain,
		input logic [KEY_WIDTH-1:0] userKey,
		input string name
	);
		driveGoPulse(plain, userKey);
		expectedCipher <= serpentModel(plain, userKey);
		testName = name;
	endtask

	task automatic waitForDone(input int limit);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!done && (cycles < limit))
		begin
			@(posedge clk);
			cycles++;
		end
		if (!done)
		begin
			timeoutErrors++;
			$display("%s: done never arrived within %0d cycles", testName, limit);
		end
	endtask

	task automatic runCase
	(
		input logic [BLOCK_WIDTH-1:0] plain,
		input logic [KEY_WIDTH-1:0] userKey,
		input string name
	);
		startOperation(plain, userKey, name);
		waitForDone(40);
	endtask

	always @(posedge clk)
	begin
		if (!rst && done)
		begin
			doneCount <= doneCount + 1;
			assert (cipherText == expectedCipher)
			else
			begin
				checkErrors++;
				$display("[FAIL] %s expected %h actual %h", testName, expectedCipher, cipherText);
			end
		end
	end

	cipherAtDone: assert property (@(posedge clk) disable iff (rst)
		done |-> (cipherText == expectedCipher))
	else
	begin
		assertErrors++;
		$display("[FAIL] %s expected %h actual %h", testName, $sampled(expectedCipher),
			$sampled(cipherText));
	end

	initial
	begin
		int testStart;
		clk = 1'b0;
		rst = 1'b1;
		go = 1'b0;
		plainText = '0;
		key = '0;
		lcgState = 32'he937a7f9;
		expectedCipher = '0;
		testName = "reset";
		doneCount = 0;
		checkErrors = 0;
		assertErrors = 0;
		timeoutErrors = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		for (int n = 0; n < 20; n++)
		begin
			runCase(randomBlock(), randomKey(), $sformatf("random%0d", n));
		end
		runCase('0, '0, "allZero");
		runCase('1, '1, "allOne");

		startOperation(randomBlock(), randomKey(), "goWhileBusy");
		testStart = doneCount;
		repeat (5) @(posedge clk);
		driveGoPulse(randomBlock(), randomKey()); // Must be dropped by the controller
		waitForDone(40);
		repeat (40) @(posedge clk);
		assert (doneCount == testStart + 1)
		else
		begin
			checkErrors++;
			$display("[FAIL] goWhileBusy expected %0d actual %0d", 1, doneCount - testStart);
		end

		startOperation(randomBlock(), randomKey(), "backToBack");
		testStart = doneCount;
		repeat (32) @(posedge clk);
		startOperation(randomBlock(), randomKey(), "backToBack"); // Go lands in the done cycle
		waitForDone(40);
		repeat (3) @(posedge clk);
		assert (doneCount == testStart + 2)
		else
		begin
			checkErrors++;
			$display("[FAIL] backToBack expected %0d actual %0d", 2, doneCount - testStart);
		end

		startOperation(randomBlock(), randomKey(), "resetMidOp");
		repeat (12) @(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		assert (!busy && !done)
		else
		begin
			checkErrors++;
			$display("resetMidOp: busy or done stayed high while reset was asserted");
		end
		rst <= 1'b0;
		runCase(randomBlock(), randomKey(), "afterReset");

		repeat (3) @(posedge clk);
		$display("Errors: %0d immediate, %0d concurrent, %0d timeout", checkErrors,
			assertErrors, timeoutErrors);
		if ((checkErrors + assertErrors + timeoutErrors) == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
hdl/serpentAlgPkg.sv
hdl/serpentCtrlPkg.sv
hdl/serpentSboxLayer.sv
hdl/serpentControl.sv
hdl/serpentKeySchedule.sv
hdl/serpentRoundData.sv
hdl/serpentTop.sv
verification/serpentTop_properties.sv
verification/serpentTb.sv

/* Makefile */
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module serpentTb -Mdir $(BUILD_DIR) -f project.f
	@out="$$(./$(BUILD_DIR)/VserpentTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
